/* hdl/soc_macros.svh */
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// Data SRAM region
`define SRAM_WORDS 256
`define SRAM_BASE  32'h0000_0000

// Peripheral region split in 256 byte slots
`define PERIPH_BASE 32'h1000_0000
`define PERIPH_SIZE 32'h0000_1000
`define SLOT_SIZE   256
`define GPIO_SLOT   0
`define TIMER_SLOT  1
`define IRQ_SLOT    2

`define GPIO_OUT     8'h00
`define GPIO_IN      8'h04
`define GPIO_IRQ_EN  8'h08
`define GPIO_STATUS  8'h0C
`define TIMER_CTRL   8'h00
`define TIMER_CMP    8'h04
`define TIMER_COUNT  8'h08
`define TIMER_STATUS 8'h0C
`define IRQ_MASK     8'h00
`define IRQ_PENDING  8'h04

`define GPIO_OUT_W 12
`define GPIO_IN_W  4

`define IRQ_SRC_W     32
`define IRQ_GPIO_BIT  24  // Same spots as the old event unit
`define IRQ_TIMER_BIT 25

`endif

/* hdl/soc_pkg.sv */
`include "soc_macros.svh"

package soc_pkg;

  typedef logic [`SOC_ADDR_W-1:0]          addr_t;
  typedef logic [`SOC_DATA_W-1:0]          data_t;
  typedef logic [$clog2(`SLOT_SIZE)-1:0]   reg_off_t;   // Offset inside a slot
  typedef logic [$clog2(`SRAM_WORDS)-1:0]  sram_idx_t;  // Word index
  typedef logic [`GPIO_OUT_W-1:0]          gpio_out_t;
  typedef logic [`GPIO_IN_W-1:0]           gpio_in_t;
  typedef logic [`IRQ_SRC_W-1:0]           irq_vec_t;
  typedef logic [$clog2(`IRQ_SRC_W)-1:0]   irq_id_t;

  // Host side sequencer
  typedef enum logic [1:0] {
    IDLE,
    SRAM_RD,
    PERIPH_WAIT,
    RSP_HOLD
  } dec_state_e;

  // Peripheral bus phases
  typedef enum logic [1:0] {
    BR_IDLE,
    BR_SETUP,
    BR_ACCESS
  } bridge_state_e;

endpackage

/* hdl/data_sram.sv */
`include "soc_macros.svh"

module data_sram (
  input  logic               core_clk,
  input  logic               sram_en_i,
  input  logic               sram_we_i,
  input  soc_pkg::sram_idx_t sram_idx_i,
  input  soc_pkg::data_t     sram_wdata_i,
  output soc_pkg::data_t     sram_rdata_o
);

  soc_pkg::data_t mem [0:`SRAM_WORDS-1];

  // Single port, read data registered
  always_ff @(posedge core_clk) begin
    if (sram_en_i) begin
      if (sram_we_i) begin
        mem[sram_idx_i] <= sram_wdata_i;
      end else begin
        sram_rdata_o <= mem[sram_idx_i];
      end
    end
  end

endmodule

/* hdl/bus_decoder.sv */
`include "soc_macros.svh"

module bus_decoder (
  input  logic               core_clk,
  input  logic               reset_n,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  logic               req_write_i,
  input  soc_pkg::addr_t     req_addr_i,
  input  soc_pkg::data_t     req_wdata_i,
  output logic               rsp_valid_o,
  input  logic               rsp_ready_i,
  output soc_pkg::data_t     rsp_rdata_o,
  output logic               rsp_error_o,
  output logic               sram_en_o,
  output logic               sram_we_o,
  output soc_pkg::sram_idx_t sram_idx_o,
  output soc_pkg::data_t     sram_wdata_o,
  input  soc_pkg::data_t     sram_rdata_i,
  output logic               periph_req_o,
  output logic               periph_write_o,
  output soc_pkg::addr_t     periph_addr_o,
  output soc_pkg::data_t     periph_wdata_o,
  input  logic               periph_done_i,
  input  soc_pkg::data_t     periph_rdata_i,
  input  logic               periph_err_i
);

  soc_pkg::dec_state_e state_q;
  soc_pkg::addr_t      sram_off;
  soc_pkg::addr_t      periph_off;
  logic                hit_sram;
  logic                hit_periph;
  logic                accept;
  logic                wr_q;
  logic                sram_cap;
  logic                periph_cap;

  // Below-base addresses wrap to large offsets and miss
  assign sram_off   = req_addr_i - `SRAM_BASE;
  assign periph_off = req_addr_i - `PERIPH_BASE;
  assign hit_sram   = sram_off < `SRAM_WORDS * 4;
  assign hit_periph = periph_off < `PERIPH_SIZE;

  assign req_ready_o = state_q == soc_pkg::IDLE;
  assign accept      = req_valid_i & req_ready_o;
  assign rsp_valid_o = state_q == soc_pkg::RSP_HOLD;
  assign sram_cap    = (state_q == soc_pkg::SRAM_RD) & ~sram_en_o;  // Read data on bus now
  assign periph_cap  = (state_q == soc_pkg::PERIPH_WAIT) & periph_done_i;

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q        <= soc_pkg::IDLE;
      wr_q           <= 1'b0;
      sram_en_o      <= 1'b0;
      sram_we_o      <= 1'b0;
      periph_req_o   <= 1'b0;
      periph_write_o <= 1'b0;
      rsp_error_o    <= 1'b0;
    end else begin
      periph_req_o <= 1'b0;  // Single cycle strobe
      case (state_q)
        soc_pkg::IDLE: begin
          if (accept) begin
            wr_q <= req_write_i;
            if (hit_sram) begin
              sram_en_o <= 1'b1;
              sram_we_o <= req_write_i;
              state_q   <= soc_pkg::SRAM_RD;
            end else if (hit_periph) begin
              periph_req_o   <= 1'b1;
              periph_write_o <= req_write_i;
              state_q        <= soc_pkg::PERIPH_WAIT;
            end else begin
              rsp_error_o <= 1'b1;
              state_q     <= soc_pkg::RSP_HOLD;
            end
          end
        end
        soc_pkg::SRAM_RD: begin
          if (sram_en_o) begin
            sram_en_o <= 1'b0;
            sram_we_o <= 1'b0;
          end else begin
            state_q <= soc_pkg::RSP_HOLD;
          end
        end
        soc_pkg::PERIPH_WAIT: begin
          if (periph_done_i) begin
            rsp_error_o <= periph_err_i;
            state_q     <= soc_pkg::RSP_HOLD;
          end
        end
        soc_pkg::RSP_HOLD: begin
          if (rsp_ready_i) begin
            rsp_error_o <= 1'b0;
            state_q     <= soc_pkg::IDLE;
          end
        end
        default: state_q <= soc_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge core_clk) begin
    if (accept) begin
      sram_idx_o     <= sram_off[$clog2(`SRAM_WORDS)+1:2];
      sram_wdata_o   <= req_wdata_i;
      periph_addr_o  <= periph_off;  // Region relative
      periph_wdata_o <= req_wdata_i;
      rsp_rdata_o    <= '0;
    end else if (sram_cap) begin
      rsp_rdata_o <= wr_q ? '0 : sram_rdata_i;
    end else if (periph_cap) begin
      rsp_rdata_o <= wr_q ? '0 : periph_rdata_i;
    end
  end

endmodule

/* hdl/periph_bridge.sv */
`include "soc_macros.svh"

module periph_bridge (
  input  logic              core_clk,
  input  logic              reset_n,
  input  logic              periph_req_i,
  input  logic              periph_write_i,
  input  soc_pkg::addr_t    periph_addr_i,
  input  soc_pkg::data_t    periph_wdata_i,
  output logic              periph_done_o,
  output soc_pkg::data_t    periph_rdata_o,
  output logic              periph_err_o,
  output logic              gpio_sel_o,
  output logic              timer_sel_o,
  output logic              irq_sel_o,
  output logic              penable_o,
  output logic              pwrite_o,
  output soc_pkg::reg_off_t paddr_o,
  output soc_pkg::data_t    pwdata_o,
  input  soc_pkg::data_t    gpio_rdata_i,
  input  soc_pkg::data_t    timer_rdata_i,
  input  soc_pkg::data_t    irq_rdata_i
);

  soc_pkg::bridge_state_e state_q;
  logic [$clog2(`PERIPH_SIZE)-$clog2(`SLOT_SIZE)-1:0] slot_q;
  logic active;
  logic slot_hit;

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q  <= soc_pkg::BR_IDLE;
      slot_q   <= '0;
      pwrite_o <= 1'b0;
    end else begin
      case (state_q)
        soc_pkg::BR_IDLE: begin
          if (periph_req_i) begin
            slot_q   <= periph_addr_i[$clog2(`PERIPH_SIZE)-1:$clog2(`SLOT_SIZE)];
            pwrite_o <= periph_write_i;
            state_q  <= soc_pkg::BR_SETUP;
          end
        end
        soc_pkg::BR_SETUP:  state_q <= soc_pkg::BR_ACCESS;
        soc_pkg::BR_ACCESS: state_q <= soc_pkg::BR_IDLE;
        default:            state_q <= soc_pkg::BR_IDLE;
      endcase
    end
  end

  always_ff @(posedge core_clk) begin
    if (state_q == soc_pkg::BR_IDLE && periph_req_i) begin
      paddr_o  <= periph_addr_i[$clog2(`SLOT_SIZE)-1:0];
      pwdata_o <= periph_wdata_i;
    end
  end

  assign active      = state_q != soc_pkg::BR_IDLE;
  assign gpio_sel_o  = active & (slot_q == `GPIO_SLOT);
  assign timer_sel_o = active & (slot_q == `TIMER_SLOT);
  assign irq_sel_o   = active & (slot_q == `IRQ_SLOT);
  assign penable_o   = state_q == soc_pkg::BR_ACCESS;
  assign slot_hit    = gpio_sel_o | timer_sel_o | irq_sel_o;

  // Completion is the access cycle itself
  assign periph_done_o = penable_o;
  assign periph_err_o  = penable_o & ~slot_hit;

  always_comb begin
    case (slot_q)
      `GPIO_SLOT:  periph_rdata_o = gpio_rdata_i;
      `TIMER_SLOT: periph_rdata_o = timer_rdata_i;
      `IRQ_SLOT:   periph_rdata_o = irq_rdata_i;
      default:     periph_rdata_o = '0;  // Unused slot
    endcase
  end

endmodule

/* hdl/gpio_port.sv */
`include "soc_macros.svh"

module gpio_port (
  input  logic               core_clk,
  input  logic               reset_n,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  soc_pkg::reg_off_t  paddr_i,
  input  soc_pkg::data_t     pwdata_i,
  output soc_pkg::data_t     prdata_o,
  input  soc_pkg::gpio_in_t  gpio_in_i,
  output soc_pkg::gpio_out_t gpio_out_o,
  output logic               gpio_irq_o
);

  soc_pkg::gpio_in_t sync_q1;
  soc_pkg::gpio_in_t sync_q2;
  soc_pkg::gpio_in_t prev_q;
  soc_pkg::gpio_in_t irq_en_q;
  soc_pkg::gpio_in_t status_q;
  soc_pkg::gpio_in_t rise;
  logic              wr_en;

  assign wr_en = psel_i & penable_i & pwrite_i;
  assign rise  = sync_q2 & ~prev_q & irq_en_q;

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      sync_q1    <= '0;
      sync_q2    <= '0;
      prev_q     <= '0;
      irq_en_q   <= '0;
      status_q   <= '0;
      gpio_out_o <= '0;
    end else begin
      sync_q1 <= gpio_in_i;
      sync_q2 <= sync_q1;
      prev_q  <= sync_q2;
      if (wr_en && paddr_i == `GPIO_OUT) gpio_out_o <= pwdata_i[`GPIO_OUT_W-1:0];
      if (wr_en && paddr_i == `GPIO_IRQ_EN) irq_en_q <= pwdata_i[`GPIO_IN_W-1:0];
      // New edge wins over a write-1 clear
      if (wr_en && paddr_i == `GPIO_STATUS) begin
        status_q <= (status_q & ~pwdata_i[`GPIO_IN_W-1:0]) | rise;
      end else begin
        status_q <= status_q | rise;
      end
    end
  end

  assign gpio_irq_o = |status_q;

  always_comb begin
    case (paddr_i)
      `GPIO_OUT:    prdata_o = soc_pkg::data_t'(gpio_out_o);
      `GPIO_IN:     prdata_o = soc_pkg::data_t'(sync_q2);
      `GPIO_IRQ_EN: prdata_o = soc_pkg::data_t'(irq_en_q);
      `GPIO_STATUS: prdata_o = soc_pkg::data_t'(status_q);
      default:      prdata_o = '0;
    endcase
  end

endmodule

/* hdl/timer_unit.sv */
`include "soc_macros.svh"

module timer_unit (
  input  logic              core_clk,
  input  logic              reset_n,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  soc_pkg::reg_off_t paddr_i,
  input  soc_pkg::data_t    pwdata_i,
  output soc_pkg::data_t    prdata_o,
  output logic              timer_irq_o
);

  logic           en_q;
  soc_pkg::data_t cmp_q;
  soc_pkg::data_t count_q;
  logic           status_q;
  logic           wr_en;
  logic           hit;

  assign wr_en = psel_i & penable_i & pwrite_i;
  assign hit   = en_q & (count_q == cmp_q);

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      en_q     <= 1'b0;
      cmp_q    <= '0;
      count_q  <= '0;
      status_q <= 1'b0;
    end else begin
      if (wr_en && paddr_i == `TIMER_CTRL) en_q <= pwdata_i[0];
      if (wr_en && paddr_i == `TIMER_CMP) cmp_q <= pwdata_i;
      if (wr_en && paddr_i == `TIMER_COUNT) begin
        count_q <= pwdata_i;
      end else if (hit) begin
        count_q <= '0;  // Wrap on match
      end else if (en_q) begin
        count_q <= count_q + 1'b1;
      end
      if (hit) begin
        status_q <= 1'b1;
      end else if (wr_en && paddr_i == `TIMER_STATUS && pwdata_i[0]) begin
        status_q <= 1'b0;
      end
    end
  end

  assign timer_irq_o = status_q;

  always_comb begin
    case (paddr_i)
      `TIMER_CTRL:   prdata_o = soc_pkg::data_t'(en_q);
      `TIMER_CMP:    prdata_o = cmp_q;
      `TIMER_COUNT:  prdata_o = count_q;
      `TIMER_STATUS: prdata_o = soc_pkg::data_t'(status_q);
      default:       prdata_o = '0;
    endcase
  end

endmodule

/* hdl/irq_ctrl.sv */
`include "soc_macros.svh"

module irq_ctrl (
  input  logic              core_clk,
  input  logic              reset_n,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  soc_pkg::reg_off_t paddr_i,
  input  soc_pkg::data_t    pwdata_i,
  output soc_pkg::data_t    prdata_o,
  input  soc_pkg::irq_vec_t irq_src_i,
  output logic              irq_o,
  output soc_pkg::irq_id_t  irq_id_o
);

  soc_pkg::irq_vec_t mask_q;
  soc_pkg::irq_vec_t pending;

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      mask_q <= '0;
    end else if (psel_i && penable_i && pwrite_i && paddr_i == `IRQ_MASK) begin
      mask_q <= pwdata_i;
    end
  end

  assign pending = irq_src_i & mask_q;
  assign irq_o   = |pending;

  // Highest set bit wins
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < `IRQ_SRC_W; i++) begin
      if (pending[i]) irq_id_o = soc_pkg::irq_id_t'(i);
    end
  end

  always_comb begin
    case (paddr_i)
      `IRQ_MASK:    prdata_o = mask_q;
      `IRQ_PENDING: prdata_o = pending;  // Read only
      default:      prdata_o = '0;
    endcase
  end

endmodule

/* hdl/soc_top.sv */
`include "soc_macros.svh"

module soc_top (
  input  logic              core_clk,
  input  logic              reset_n,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic              req_write_i,
  input  soc_pkg::addr_t    req_addr_i,
  input  soc_pkg::data_t    req_wdata_i,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output soc_pkg::data_t    rsp_rdata_o,
  output logic              rsp_error_o,
  input  soc_pkg::gpio_in_t gpio_in_i,
  output soc_pkg::gpio_out_t gpio_out_o,
  output logic              irq_o,
  output soc_pkg::irq_id_t  irq_id_o
);

  logic                sram_en;
  logic                sram_we;
  soc_pkg::sram_idx_t  sram_idx;
  soc_pkg::data_t      sram_wdata;
  soc_pkg::data_t      sram_rdata;

  logic                periph_req;
  logic                periph_write;
  soc_pkg::addr_t      periph_addr;
  soc_pkg::data_t      periph_wdata;
  logic                periph_done;
  soc_pkg::data_t      periph_rdata;
  logic                periph_err;

  logic                gpio_sel;
  logic                timer_sel;
  logic                irq_sel;
  logic                penable;
  logic                pwrite;
  soc_pkg::reg_off_t   paddr;
  soc_pkg::data_t      pwdata;
  soc_pkg::data_t      gpio_rdata;
  soc_pkg::data_t      timer_rdata;
  soc_pkg::data_t      irq_rdata;

  logic                gpio_irq;
  logic                timer_irq;
  soc_pkg::irq_vec_t   irq_src;

  always_comb begin
    irq_src = '0;
    irq_src[`IRQ_GPIO_BIT]  = gpio_irq;
    irq_src[`IRQ_TIMER_BIT] = timer_irq;
  end

  bus_decoder u_decoder (
    .core_clk, .reset_n,
    .req_valid_i, .req_ready_o, .req_write_i, .req_addr_i, .req_wdata_i,
    .rsp_valid_o, .rsp_ready_i, .rsp_rdata_o, .rsp_error_o,
    .sram_en_o(sram_en), .sram_we_o(sram_we), .sram_idx_o(sram_idx),
    .sram_wdata_o(sram_wdata), .sram_rdata_i(sram_rdata),
    .periph_req_o(periph_req), .periph_write_o(periph_write),
    .periph_addr_o(periph_addr), .periph_wdata_o(periph_wdata),
    .periph_done_i(periph_done), .periph_rdata_i(periph_rdata), .periph_err_i(periph_err)
  );

  data_sram u_sram (
    .core_clk,
    .sram_en_i(sram_en), .sram_we_i(sram_we), .sram_idx_i(sram_idx),
    .sram_wdata_i(sram_wdata), .sram_rdata_o(sram_rdata)
  );

  periph_bridge u_bridge (
    .core_clk, .reset_n,
    .periph_req_i(periph_req), .periph_write_i(periph_write),
    .periph_addr_i(periph_addr), .periph_wdata_i(periph_wdata),
    .periph_done_o(periph_done), .periph_rdata_o(periph_rdata), .periph_err_o(periph_err),
    .gpio_sel_o(gpio_sel), .timer_sel_o(timer_sel), .irq_sel_o(irq_sel),
    .penable_o(penable), .pwrite_o(pwrite), .paddr_o(paddr), .pwdata_o(pwdata),
    .gpio_rdata_i(gpio_rdata), .timer_rdata_i(timer_rdata), .irq_rdata_i(irq_rdata)
  );

  gpio_port u_gpio (
    .core_clk, .reset_n,
    .psel_i(gpio_sel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
    .pwdata_i(pwdata), .prdata_o(gpio_rdata),
    .gpio_in_i, .gpio_out_o, .gpio_irq_o(gpio_irq)
  );

  timer_unit u_timer (
    .core_clk, .reset_n,
    .psel_i(timer_sel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
    .pwdata_i(pwdata), .prdata_o(timer_rdata), .timer_irq_o(timer_irq)
  );

  irq_ctrl u_irq (
    .core_clk, .reset_n,
    .psel_i(irq_sel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
    .pwdata_i(pwdata), .prdata_o(irq_rdata),
    .irq_src_i(irq_src), .irq_o, .irq_id_o
  );

endmodule

/* verif/soc_tb_tasks.svh */
// Galois LFSR, one step per returned bit
function automatic soc_pkg::data_t rand_bits(input int nbits);
  soc_pkg::data_t val;
  val = '0;
  for (int i = 0; i < nbits; i++) begin
    lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
    val = {val[30:0], lfsr_state[0]};
  end
  return val;
endfunction

task automatic check(input string what, input soc_pkg::data_t expected,
                     input soc_pkg::data_t actual);
  if (expected !== actual) begin
    stop_run($sformatf("[FAIL] %s %s: expected %h actual %h",
                       test_name, what, expected, actual));
  end
endtask

// One request and one response, response held off for hold cycles
task automatic bus_access(input logic write, input soc_pkg::addr_t addr,
                          input soc_pkg::data_t wdata, input int hold,
                          output soc_pkg::data_t rdata, output logic err);
  int cnt;
  @(posedge core_clk);
  req_valid <= 1'b1;
  req_write <= write;
  req_addr  <= addr;
  req_wdata <= wdata;
  cnt = 0;
  @(negedge core_clk);
  while (req_ready !== 1'b1) begin
    cnt++;
    if (cnt > wait_limit) stop_run("Timed out waiting for the request to be accepted");
    @(negedge core_clk);
  end
  @(posedge core_clk);  // Handshake edge
  req_valid <= 1'b0;
  cnt = 0;
  @(negedge core_clk);
  while (rsp_valid !== 1'b1) begin
    cnt++;
    if (cnt > wait_limit) stop_run("Timed out waiting for a response");
    @(negedge core_clk);
  end
  rdata = rsp_rdata;
  err   = rsp_error;
  repeat (hold) begin
    @(negedge core_clk);
    check("held rsp_valid", 1, rsp_valid);
    check("held rdata", rdata, rsp_rdata);
    check("held error", err, rsp_error);
    check("held req_ready", 0, req_ready);
  end
  @(posedge core_clk);
  rsp_ready <= 1'b1;
  @(posedge core_clk);
  rsp_ready <= 1'b0;
endtask

task automatic bus_write(input soc_pkg::addr_t addr, input soc_pkg::data_t wdata,
                         input logic exp_err);
  soc_pkg::data_t rd;
  logic           err;
  bus_access(1'b1, addr, wdata, 0, rd, err);
  check("write error flag", exp_err, err);
  check("write rdata", 0, rd);
endtask

task automatic bus_read(input soc_pkg::addr_t addr, input int hold, input logic exp_err,
                        output soc_pkg::data_t rdata);
  logic err;
  bus_access(1'b0, addr, '0, hold, rdata, err);
  check("read error flag", exp_err, err);
  if (exp_err) check("error rdata", 0, rdata);
endtask

task automatic wait_irq(input logic level);
  int cnt;
  cnt = 0;
  @(negedge core_clk);
  while (irq !== level) begin
    cnt++;
    if (cnt > wait_limit) stop_run("Timed out waiting for the interrupt line to change");
    @(negedge core_clk);
  end
endtask

task automatic wait_id_change(input soc_pkg::irq_id_t from);
  int cnt;
  cnt = 0;
  @(negedge core_clk);
  while (irq_id === from) begin
    cnt++;
    if (cnt > wait_limit) stop_run("Timed out waiting for the interrupt id to change");
    @(negedge core_clk);
  end
endtask

task automatic sram_rw_test();
  soc_pkg::sram_idx_t idx [8];
  soc_pkg::data_t     wd;
  soc_pkg::data_t     rd;
  test_name = "sram_rw";
  for (int i = 0; i < 8; i++) begin
    idx[i] = soc_pkg::sram_idx_t'(rand_bits(8));
    wd = rand_bits(32);
    exp_mem[idx[i]] = wd;  // Repeated index keeps the last value
    bus_write(`SRAM_BASE + 4 * idx[i], wd, 1'b0);
  end
  for (int i = 0; i < 8; i++) begin
    bus_read(`SRAM_BASE + 4 * idx[i], int'(rand_bits(3)), 1'b0, rd);
    check("read back", exp_mem[idx[i]], rd);
  end
endtask

task automatic error_rsp_test();
  soc_pkg::data_t rd;
  test_name = "error_rsp";
  exp_mem[0] = rand_bits(32);
  bus_write(`SRAM_BASE, exp_mem[0], 1'b0);
  // First byte past the SRAM would alias word 0 without a decode
  bus_write(`SRAM_BASE + `SRAM_WORDS * 4, rand_bits(32), 1'b1);
  bus_read(32'h2000_0000, 1, 1'b1, rd);
  bus_write(`PERIPH_BASE + 5 * `SLOT_SIZE, rand_bits(32), 1'b1);
  bus_read(`PERIPH_BASE + 5 * `SLOT_SIZE + 4, 2, 1'b1, rd);
  bus_read(`SRAM_BASE, 0, 1'b0, rd);
  check("word 0 after errors", exp_mem[0], rd);
endtask

task automatic gpio_pin_test();
  soc_pkg::data_t    wd;
  soc_pkg::data_t    rd;
  soc_pkg::gpio_in_t pins;
  test_name = "gpio_pins";
  wd = rand_bits(32) | 32'h8000_0000;  // Bits above the 12 pins set
  bus_write(gpio_base + `GPIO_OUT, wd, 1'b0);
  @(negedge core_clk);
  check("gpio_out pins", wd & out_mask, gpio_out);
  bus_read(gpio_base + `GPIO_OUT, 0, 1'b0, rd);
  check("GPIO_OUT readback", wd & out_mask, rd);
  for (int i = 0; i < 3; i++) begin
    pins = soc_pkg::gpio_in_t'(rand_bits(4));
    @(posedge core_clk);
    gpio_in <= pins;
    repeat (3) @(posedge core_clk);  // Let the synchronizer settle
    bus_read(gpio_base + `GPIO_IN, 0, 1'b0, rd);
    check("GPIO_IN", pins, rd);
  end
  @(posedge core_clk);
  gpio_in <= '0;
endtask

task automatic timer_irq_test();
  soc_pkg::data_t rd;
  test_name = "timer_irq";
  bus_write(irq_base + `IRQ_MASK, timer_bit_v, 1'b0);
  bus_write(timer_base + `TIMER_COUNT, 0, 1'b0);
  bus_write(timer_base + `TIMER_CMP, 4 + rand_bits(4), 1'b0);
  @(negedge core_clk);
  check("irq before enable", 0, irq);
  bus_write(timer_base + `TIMER_CTRL, 1, 1'b0);
  wait_irq(1'b1);
  check("irq id", `IRQ_TIMER_BIT, irq_id);
  bus_read(irq_base + `IRQ_PENDING, 0, 1'b0, rd);
  check("IRQ_PENDING", timer_bit_v, rd);
  bus_write(timer_base + `TIMER_CTRL, 0, 1'b0);
  bus_write(timer_base + `TIMER_STATUS, 1, 1'b0);
  @(negedge core_clk);
  check("irq after clear", 0, irq);
endtask

task automatic irq_priority_test();
  soc_pkg::data_t rd;
  test_name = "irq_priority";
  bus_write(gpio_base + `GPIO_IRQ_EN, 1, 1'b0);
  bus_write(irq_base + `IRQ_MASK, gpio_bit_v, 1'b0);
  @(negedge core_clk);
  check("irq before edge", 0, irq);
  @(posedge core_clk);
  gpio_in <= 4'b0001;
  wait_irq(1'b1);
  check("gpio only id", `IRQ_GPIO_BIT, irq_id);
  bus_read(irq_base + `IRQ_PENDING, 0, 1'b0, rd);
  check("pending gpio", gpio_bit_v, rd);
  bus_write(irq_base + `IRQ_MASK, gpio_bit_v | timer_bit_v, 1'b0);
  bus_write(timer_base + `TIMER_COUNT, 0, 1'b0);
  bus_write(timer_base + `TIMER_CMP, 4 + rand_bits(4), 1'b0);
  bus_write(timer_base + `TIMER_CTRL, 1, 1'b0);
  wait_id_change(`IRQ_GPIO_BIT);
  check("timer over gpio id", `IRQ_TIMER_BIT, irq_id);
  bus_read(irq_base + `IRQ_PENDING, 0, 1'b0, rd);
  check("pending both", gpio_bit_v | timer_bit_v, rd);
  bus_write(timer_base + `TIMER_CTRL, 0, 1'b0);
  bus_write(timer_base + `TIMER_STATUS, 1, 1'b0);
  @(negedge core_clk);
  check("id after timer clear", `IRQ_GPIO_BIT, irq_id);
  check("irq still high", 1, irq);
  bus_read(irq_base + `IRQ_PENDING, 0, 1'b0, rd);
  check("pending gpio again", gpio_bit_v, rd);
  bus_write(gpio_base + `GPIO_STATUS, 1, 1'b0);
  @(negedge core_clk);
  check("irq after gpio clear", 0, irq);
endtask

/* verif/soc_tb.sv */
`include "soc_macros.svh"

module soc_tb;

  localparam int wait_limit = 200;  // Cycles per wait loop
  localparam soc_pkg::addr_t gpio_base  = `PERIPH_BASE + `GPIO_SLOT * `SLOT_SIZE;
  localparam soc_pkg::addr_t timer_base = `PERIPH_BASE + `TIMER_SLOT * `SLOT_SIZE;
  localparam soc_pkg::addr_t irq_base   = `PERIPH_BASE + `IRQ_SLOT * `SLOT_SIZE;
  localparam soc_pkg::irq_vec_t gpio_bit_v  = 32'd1 << `IRQ_GPIO_BIT;
  localparam soc_pkg::irq_vec_t timer_bit_v = 32'd1 << `IRQ_TIMER_BIT;
  localparam soc_pkg::data_t out_mask = (32'd1 << `GPIO_OUT_W) - 1;

  logic               core_clk;
  logic               reset_n;
  logic               req_valid;
  logic               req_ready;
  logic               req_write;
  soc_pkg::addr_t     req_addr;
  soc_pkg::data_t     req_wdata;
  logic               rsp_valid;
  logic               rsp_ready;
  soc_pkg::data_t     rsp_rdata;
  logic               rsp_error;
  soc_pkg::gpio_in_t  gpio_in;
  soc_pkg::gpio_out_t gpio_out;
  logic               irq;
  soc_pkg::irq_id_t   irq_id;

  string              test_name;
  logic [31:0]        lfsr_state;
  soc_pkg::data_t     exp_mem [0:`SRAM_WORDS-1];  // Reference copy of SRAM words

  soc_top UUT (
    .core_clk    (core_clk),
    .reset_n     (reset_n),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_write_i (req_write),
    .req_addr_i  (req_addr),
    .req_wdata_i (req_wdata),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .rsp_rdata_o (rsp_rdata),
    .rsp_error_o (rsp_error),
    .gpio_in_i   (gpio_in),
    .gpio_out_o  (gpio_out),
    .irq_o       (irq),
    .irq_id_o    (irq_id)
  );

  initial begin
    core_clk = 1'b0;
    forever #10 core_clk = ~core_clk;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  `include "soc_tb_tasks.svh"

  task automatic check_reset_state();
    soc_pkg::data_t rd;
    test_name = "reset";
    @(negedge core_clk);
    check("rsp_valid", 0, rsp_valid);
    check("req_ready", 1, req_ready);
    check("gpio_out", 0, gpio_out);
    check("irq", 0, irq);
    check("irq_id", 0, irq_id);
    bus_read(irq_base + `IRQ_MASK, 0, 1'b0, rd);
    check("IRQ_MASK", 0, rd);
    bus_read(timer_base + `TIMER_CTRL, 0, 1'b0, rd);
    check("TIMER_CTRL", 0, rd);
    bus_read(timer_base + `TIMER_CMP, 0, 1'b0, rd);
    check("TIMER_CMP", 0, rd);
    bus_read(timer_base + `TIMER_COUNT, 0, 1'b0, rd);
    check("TIMER_COUNT", 0, rd);
    bus_read(timer_base + `TIMER_STATUS, 0, 1'b0, rd);
    check("TIMER_STATUS", 0, rd);
    bus_read(gpio_base + `GPIO_IRQ_EN, 0, 1'b0, rd);
    check("GPIO_IRQ_EN", 0, rd);
    bus_read(gpio_base + `GPIO_STATUS, 0, 1'b0, rd);
    check("GPIO_STATUS", 0, rd);
  endtask

  initial begin
    reset_n    = 1'b0;
    req_valid  = 1'b0;
    req_write  = 1'b0;
    req_addr   = '0;
    req_wdata  = '0;
    rsp_ready  = 1'b0;
    gpio_in    = '0;
    lfsr_state = 32'hd323_5276;
    test_name  = "startup";
    repeat (3) @(posedge core_clk);
    reset_n <= 1'b1;

    check_reset_state();
    sram_rw_test();
    error_rsp_test();
    gpio_pin_test();
    timer_irq_test();
    irq_priority_test();

    $display("Verification passed");
    $finish;
  end

endmodule

/* periph_soc.f */
+incdir+hdl
+incdir+verif
hdl/soc_pkg.sv
hdl/data_sram.sv
hdl/bus_decoder.sv
hdl/periph_bridge.sv
hdl/gpio_port.sv
hdl/timer_unit.sv
hdl/irq_ctrl.sv
hdl/soc_top.sv
verif/soc_tb.sv

/* Bender.yml */
package:
  name: periph_soc

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/soc_pkg.sv
      - hdl/data_sram.sv
      - hdl/bus_decoder.sv
      - hdl/periph_bridge.sv
      - hdl/gpio_port.sv
      - hdl/timer_unit.sv
      - hdl/irq_ctrl.sv
      - hdl/soc_top.sv
  - target: test
    include_dirs:
      - hdl
      - verif
    files:
      - verif/soc_tb.sv
